// File: include/icache_consts.svh
////////////////////////////////////////////////////////////////////////////
// instruction cache constants
// address and block geometry, line count, index and tag field
// positions, default prefetch window size
////////////////////////////////////////////////////////////////////////////

`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// byte address as seen by fetch and by the memory port
`define ICACHE_ADDR_BITS 16

// one block is 64 bits, 8 bytes
`define ICACHE_BLOCK_DATA_BITS 64
`define ICACHE_BLOCK_BYTES 8
`define ICACHE_OFFSET_BITS 3

// block number, address bits 15 down to 3
`define ICACHE_BLOCK_BITS 13

// direct mapped, 32 lines
`define ICACHE_LINES 32
`define ICACHE_INDEX_BITS 5
`define ICACHE_TAG_BITS 8

// field positions inside a byte address
`define ICACHE_INDEX_LSB 3
`define ICACHE_TAG_LSB 8

// blocks handed to fetch per lookup
`define ICACHE_PREFETCH_DISTANCE 2

`endif

// File: hdl/icache_pkg.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache package
// vector types for addresses, block numbers, index, tag and data,
// fill engine state encoding
////////////////////////////////////////////////////////////////////////////

`include "icache_consts.svh"

package icache_pkg;

    // byte address from fetch, block aligned on the bus
    typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;

    // block number, wraps modulo 2**13 across the window
    typedef logic [`ICACHE_BLOCK_BITS-1:0] block_addr_t;

    // low bits of the block number
    typedef logic [`ICACHE_INDEX_BITS-1:0] line_index_t;

    // high bits of the block number
    typedef logic [`ICACHE_TAG_BITS-1:0] line_tag_t;

    // one cached block
    typedef logic [`ICACHE_BLOCK_DATA_BITS-1:0] mem_block_t;

    // blocking fill sequence
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQ,
        FILL_WRITE
    } fill_state_t;

endpackage

// File: hdl/icache_data_array.sv
////////////////////////////////////////////////////////////////////////////
// cache block storage
// one registered write port, READ_PORTS combinational read ports,
// no write to read bypass
////////////////////////////////////////////////////////////////////////////

`include "icache_consts.svh"

module icache_data_array #(
    parameter int READ_PORTS = `ICACHE_PREFETCH_DISTANCE,
    parameter int DEPTH      = `ICACHE_LINES
) (
    input  logic                                        clock,

    // fill side
    input  logic                                        write_en,
    input  logic [$clog2(DEPTH)-1:0]                    write_index,
    input  icache_pkg::mem_block_t                      write_data,

    // window side, one index per slot
    input  logic [READ_PORTS-1:0][$clog2(DEPTH)-1:0]    read_index,
    output icache_pkg::mem_block_t [READ_PORTS-1:0]     read_data
);

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    // contents only mean something once the tag store marks the line valid
    icache_pkg::mem_block_t mem [DEPTH];

    // write lands at the edge after write_en is seen
    always_ff @(posedge clock) begin
        if (write_en) begin
            mem[write_index] <= write_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////////////////////

    // one independent lookup per window slot
    // a same-cycle write is not forwarded
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            read_data[r] = mem[read_index[r]];
        end
    end

endmodule

// File: hdl/icache_tag_store.sv
////////////////////////////////////////////////////////////////////////////
// cache line state
// tag, valid and alloc per line, window index and tag computation,
// valid and alloc outputs for fetch, squash of pending allocations
////////////////////////////////////////////////////////////////////////////

`include "icache_consts.svh"

module icache_tag_store #(
    parameter int PREFETCH_DISTANCE = `ICACHE_PREFETCH_DISTANCE
) (
    input  logic                                              clock,
    input  logic                                              reset,

    // fetch side
    input  icache_pkg::addr_t                                 fetch_addr,
    input  logic                                              squash,

    // fill engine
    input  logic                                              alloc_en,
    input  icache_pkg::addr_t                                 alloc_addr,
    input  logic                                              write_en,
    input  icache_pkg::addr_t                                 write_addr,

    // to data array and fetch
    output icache_pkg::line_index_t [PREFETCH_DISTANCE-1:0]   read_index,
    output logic [PREFETCH_DISTANCE-1:0]                      window_valid,
    output logic [PREFETCH_DISTANCE-1:0]                      window_alloc
);

    ////////////////////////////////////////////////////////////////////////////
    // line state
    ////////////////////////////////////////////////////////////////////////////

    // tag per line, qualified by line_valid
    icache_pkg::line_tag_t tag_mem [`ICACHE_LINES];

    logic [`ICACHE_LINES-1:0] line_valid;
    // fill requested for this line, not yet written
    logic [`ICACHE_LINES-1:0] line_alloc;

    // fetch block number, slot 0 of the window
    icache_pkg::block_addr_t fetch_block;

    // per slot block number and its tag
    icache_pkg::block_addr_t slot_block [PREFETCH_DISTANCE];
    icache_pkg::line_tag_t   slot_tag   [PREFETCH_DISTANCE];

    // fields of the fill addresses
    icache_pkg::line_index_t alloc_index;
    icache_pkg::line_index_t write_index;
    icache_pkg::line_tag_t   write_tag;

    assign fetch_block = fetch_addr[`ICACHE_ADDR_BITS-1:`ICACHE_INDEX_LSB];

    assign alloc_index = alloc_addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
    assign write_index = write_addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
    assign write_tag   = write_addr[`ICACHE_ADDR_BITS-1:`ICACHE_TAG_LSB];

    ////////////////////////////////////////////////////////////////////////////
    // window lookup
    ////////////////////////////////////////////////////////////////////////////

    // slot i looks at block fetch_block + i, wrapping at 2**13
    // so a window that crosses an index wrap compares the next tag
    always_comb begin
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            slot_block[i] = fetch_block + icache_pkg::block_addr_t'(i);
            slot_tag[i]   = slot_block[i][`ICACHE_BLOCK_BITS-1:`ICACHE_INDEX_BITS];
            read_index[i] = slot_block[i][`ICACHE_INDEX_BITS-1:0];

            // hit needs both valid line and matching tag
            window_valid[i] = line_valid[read_index[i]] &&
                              (tag_mem[read_index[i]] == slot_tag[i]);
            // alloc is per line, whatever tag the pending fill carries
            window_alloc[i] = line_alloc[read_index[i]];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // state update
    ////////////////////////////////////////////////////////////////////////////

    // valid and alloc bits
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
            line_alloc <= '0;
        end else begin
            // squash drops every pending allocation
            // and wins over a new alloc in the same cycle
            if (squash) begin
                line_alloc <= '0;
            end else if (alloc_en) begin
                line_alloc[alloc_index] <= 1'b1;
            end

            // a fill in flight still completes after a squash
            if (write_en) begin
                line_valid[write_index] <= 1'b1;
                line_alloc[write_index] <= 1'b0;
            end
        end
    end

    // tag written together with the data block
    always_ff @(posedge clock) begin
        if (write_en) begin
            tag_mem[write_index] <= write_tag;
        end
    end

endmodule

// File: hdl/icache_fill.sv
////////////////////////////////////////////////////////////////////////////
// blocking fill engine
// slot 0 miss detection, Wishbone classic single read master,
// data capture and one cycle line write into the cache
////////////////////////////////////////////////////////////////////////////

`include "icache_consts.svh"

module icache_fill (
    input  logic                              clock,
    input  logic                              reset,

    // fetch side
    input  icache_pkg::addr_t                 fetch_addr,
    // slot 0 hit from the tag store
    input  logic                              miss_valid,

    // allocation request to the tag store
    output logic                              alloc_en,
    output icache_pkg::addr_t                 alloc_addr,

    // line write to tag store and data array
    output logic                              write_en,
    output icache_pkg::addr_t                 write_addr,
    output icache_pkg::mem_block_t            write_data,

    // Wishbone classic master
    output logic                              wb_cyc,
    output logic                              wb_stb,
    output logic                              wb_we,
    output icache_pkg::addr_t                 wb_adr,
    output logic [`ICACHE_BLOCK_BYTES-1:0]    wb_sel,
    input  icache_pkg::mem_block_t            wb_dat_i,
    input  logic                              wb_ack
);

    icache_pkg::fill_state_t state;

    // block aligned fetch address, candidate for the next fill
    icache_pkg::addr_t miss_block_addr;

    // latched at the start of a fill, held until the write
    icache_pkg::addr_t fill_addr;

    // fetch address with the byte offset cleared
    assign miss_block_addr = {
        fetch_addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS],
        {`ICACHE_OFFSET_BITS{1'b0}}
    };

    ////////////////////////////////////////////////////////////////////////////
    // fill FSM
    ////////////////////////////////////////////////////////////////////////////

    // idle and slot 0 misses, start a fill at this edge
    assign alloc_en   = (state == icache_pkg::FILL_IDLE) && !miss_valid;
    assign alloc_addr = miss_block_addr;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= icache_pkg::FILL_IDLE;
        end else begin
            case (state)
                icache_pkg::FILL_IDLE: begin
                    if (!miss_valid) begin
                        state <= icache_pkg::FILL_REQ;
                    end
                end
                // blocking, a new fetch address does not cancel the read
                icache_pkg::FILL_REQ: begin
                    if (wb_ack) begin
                        state <= icache_pkg::FILL_WRITE;
                    end
                end
                // single write cycle
                icache_pkg::FILL_WRITE: begin
                    state <= icache_pkg::FILL_IDLE;
                end
                default: begin
                    state <= icache_pkg::FILL_IDLE;
                end
            endcase
        end
    end

    // address and data registers
    always_ff @(posedge clock) begin
        if (alloc_en) begin
            fill_addr <= miss_block_addr;
        end
        if ((state == icache_pkg::FILL_REQ) && wb_ack) begin
            write_data <= wb_dat_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus and write outputs
    ////////////////////////////////////////////////////////////////////////////

    // cyc and stb high for the whole request, drop the cycle after ack
    assign wb_cyc = (state == icache_pkg::FILL_REQ);
    assign wb_stb = (state == icache_pkg::FILL_REQ);

    // read only, full block
    assign wb_we  = 1'b0;
    assign wb_sel = '1;

    // stable from the first request cycle until ack
    assign wb_adr = fill_addr;

    // tag and data written at the edge leaving FILL_WRITE
    assign write_en   = (state == icache_pkg::FILL_WRITE);
    assign write_addr = fill_addr;

endmodule

// File: hdl/icache_top.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache top level
// fill engine, tag store and data array, fetch window outputs,
// Wishbone classic master port toward memory
////////////////////////////////////////////////////////////////////////////

`include "icache_consts.svh"

module icache_top #(
    parameter int PREFETCH_DISTANCE = `ICACHE_PREFETCH_DISTANCE
) (
    input  logic                                            clock,
    input  logic                                            reset,

    // fetch stage
    input  icache_pkg::addr_t                               fetch_addr,
    input  logic                                            squash,
    output icache_pkg::mem_block_t [PREFETCH_DISTANCE-1:0]  window_data,
    output logic [PREFETCH_DISTANCE-1:0]                    window_valid,
    output logic [PREFETCH_DISTANCE-1:0]                    window_alloc,

    // Wishbone classic master
    output logic                                            wb_cyc,
    output logic                                            wb_stb,
    output logic                                            wb_we,
    output icache_pkg::addr_t                               wb_adr,
    output logic [`ICACHE_BLOCK_BYTES-1:0]                  wb_sel,
    input  icache_pkg::mem_block_t                          wb_dat_i,
    input  logic                                            wb_ack
);

    // fill engine to tag store
    logic                   alloc_en;
    icache_pkg::addr_t      alloc_addr;

    // fill engine to tag store and data array
    logic                   write_en;
    icache_pkg::addr_t      write_addr;
    icache_pkg::mem_block_t write_data;

    // window indices, tag store to data array
    icache_pkg::line_index_t [PREFETCH_DISTANCE-1:0] read_index;

    ////////////////////////////////////////////////////////////////////////////
    // memory side
    ////////////////////////////////////////////////////////////////////////////

    // only slot 0 misses start a fill
    icache_fill u_fill (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .miss_valid (window_valid[0]),
        .alloc_en   (alloc_en),
        .alloc_addr (alloc_addr),
        .write_en   (write_en),
        .write_addr (write_addr),
        .write_data (write_data),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_sel     (wb_sel),
        .wb_dat_i   (wb_dat_i),
        .wb_ack     (wb_ack)
    );

    ////////////////////////////////////////////////////////////////////////////
    // lookup and storage
    ////////////////////////////////////////////////////////////////////////////

    icache_tag_store #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE)
    ) u_tags (
        .clock        (clock),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .squash       (squash),
        .alloc_en     (alloc_en),
        .alloc_addr   (alloc_addr),
        .write_en     (write_en),
        .write_addr   (write_addr),
        .read_index   (read_index),
        .window_valid (window_valid),
        .window_alloc (window_alloc)
    );

    // write index is the index field of the fill address
    icache_data_array #(
        .READ_PORTS (PREFETCH_DISTANCE),
        .DEPTH      (`ICACHE_LINES)
    ) u_data (
        .clock       (clock),
        .write_en    (write_en),
        .write_index (write_addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB]),
        .write_data  (write_data),
        .read_index  (read_index),
        .read_data   (window_data)
    );

endmodule

// File: testbench/icache_checker.sv
////////////////////////////////////////////////////////////////////////////
// fill engine protocol checker
// Wishbone classic read rules and the single write cycle after ack,
// bound into every icache_fill instance
////////////////////////////////////////////////////////////////////////////

module icache_checker (
    input  logic               clock,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  icache_pkg::addr_t  wb_adr,
    input  logic               wb_ack,
    input  logic               write_en
);

    // failed assertion count, read by the testbench at the end
    int violations = 0;

    // strobe only inside a cycle
    stb_within_cyc: assert property (@(posedge clock) disable iff (reset)
        wb_stb |-> wb_cyc)
        else begin
            $error("wb_stb is high while wb_cyc is low");
            violations++;
        end

    // address held through wait states
    adr_stable: assert property (@(posedge clock) disable iff (reset)
        (wb_stb && !wb_ack) |=> $stable(wb_adr))
        else begin
            $error("wb_adr changed before the read was acknowledged");
            violations++;
        end

    // read-only master
    never_write: assert property (@(posedge clock) disable iff (reset)
        !wb_we)
        else begin
            $error("wb_we went high on a read-only port");
            violations++;
        end

    // ack, then exactly one write cycle
    write_after_ack: assert property (@(posedge clock) disable iff (reset)
        (wb_stb && wb_ack) |=> write_en ##1 !write_en)
        else begin
            $error("write_en did not last exactly one cycle after ack");
            violations++;
        end

    write_needs_ack: assert property (@(posedge clock) disable iff (reset)
        write_en |-> $past(wb_stb && wb_ack))
        else begin
            $error("write_en rose without a preceding ack");
            violations++;
        end

endmodule

bind icache_fill icache_checker u_checker (
    .clock    (clock),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_ack   (wb_ack),
    .write_en (write_en)
);

// File: testbench/icache_tb.sv
////////////////////////////////////////////////////////////////////////////
// instruction cache testbench
// clock and reset, LFSR stimulus, Wishbone memory with random wait
// states, reference model of the line state, per cycle output checks
////////////////////////////////////////////////////////////////////////////

`include "icache_consts.svh"

module icache_tb;

    localparam int SLOTS       = `ICACHE_PREFETCH_DISTANCE;
    localparam int TEST_CYCLES = 500;
    localparam int FILL_LIMIT  = 40;

    logic                                clock;
    logic                                reset;
    icache_pkg::addr_t                   fetch_addr;
    logic                                squash;
    icache_pkg::mem_block_t [SLOTS-1:0]  window_data;
    logic [SLOTS-1:0]                    window_valid;
    logic [SLOTS-1:0]                    window_alloc;
    logic                                wb_cyc;
    logic                                wb_stb;
    logic                                wb_we;
    icache_pkg::addr_t                   wb_adr;
    logic [`ICACHE_BLOCK_BYTES-1:0]      wb_sel;
    icache_pkg::mem_block_t              wb_dat_i;
    logic                                wb_ack;

    // reference model state
    logic [`ICACHE_LINES-1:0]  m_valid;
    logic [`ICACHE_LINES-1:0]  m_alloc;
    icache_pkg::line_tag_t     m_tag [`ICACHE_LINES];
    icache_pkg::fill_state_t   m_state;
    icache_pkg::block_addr_t   m_fill;

    // stimulus and bookkeeping
    logic [15:0]        lfsr = 16'd60197;
    logic               bus_active = 1'b0;
    int                 wait_left;
    int                 ack_count = 0;
    int                 check_count = 0;
    int                 error_count = 0;
    int                 test_base = 0;
    int                 tests_done = 0;
    int                 violations;
    icache_pkg::addr_t  a;
    icache_pkg::addr_t  b;
    int                 start_acks;

    icache_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .squash       (squash),
        .window_data  (window_data),
        .window_valid (window_valid),
        .window_alloc (window_alloc),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_sel       (wb_sel),
        .wb_dat_i     (wb_dat_i),
        .wb_ack       (wb_ack)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // x^16 + x^14 + x^13 + x^11, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // 128 blocks over 32 lines, so four tags share each index
    function automatic icache_pkg::addr_t random_addr();
        logic [6:0] blk;
        logic [2:0] off;
        blk = 7'(rand_bits(7));
        off = 3'(rand_bits(3));
        return {6'd0, blk, off};
    endfunction

    // memory contents, a scramble of the full block address
    function automatic icache_pkg::mem_block_t block_pattern(input icache_pkg::block_addr_t blk);
        logic [15:0] x;
        x = {blk, 3'b000};
        return {x ^ 16'h5a3c, ~x, x * 16'h9e37, {x[7:0], x[15:8]} ^ 16'hc3a5};
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        check_count++;
        assert (got === exp) else begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model, memory and per cycle checks
    ////////////////////////////////////////////////////////////////////////////

    // called at the rising edge, sees the inputs of the cycle just ended
    task automatic update_model();
        icache_pkg::block_addr_t blk;
        blk = fetch_addr[15:3];
        if (wb_ack) begin
            ack_count++;
        end
        if (reset) begin
            m_valid = '0;
            m_alloc = '0;
            m_state = icache_pkg::FILL_IDLE;
        end else begin
            if (squash) begin
                m_alloc = '0;
            end
            case (m_state)
                icache_pkg::FILL_IDLE: begin
                    // slot 0 miss starts a fill, squash only blocks the alloc bit
                    if (!(m_valid[blk[4:0]] && m_tag[blk[4:0]] == blk[12:5])) begin
                        m_fill = blk;
                        m_state = icache_pkg::FILL_REQ;
                        if (!squash) begin
                            m_alloc[blk[4:0]] = 1'b1;
                        end
                    end
                end
                icache_pkg::FILL_REQ: begin
                    if (wb_ack) begin
                        m_state = icache_pkg::FILL_WRITE;
                    end
                end
                default: begin
                    m_valid[m_fill[4:0]] = 1'b1;
                    m_alloc[m_fill[4:0]] = 1'b0;
                    m_tag[m_fill[4:0]] = m_fill[12:5];
                    m_state = icache_pkg::FILL_IDLE;
                end
            endcase
        end
    endtask

    // slave with 0 to 7 wait states per read
    task automatic respond_memory();
        wb_ack = 1'b0;
        if (wb_stb) begin
            if (!bus_active) begin
                bus_active = 1'b1;
                wait_left = rand_bits(3);
            end
            if (wait_left == 0) begin
                wb_ack = 1'b1;
                wb_dat_i = block_pattern(wb_adr[15:3]);
                bus_active = 1'b0;
            end else begin
                wait_left--;
            end
        end
    endtask

    task automatic check_outputs();
        icache_pkg::block_addr_t blk;
        logic exp_valid;
        for (int i = 0; i < SLOTS; i++) begin
            // slot block wraps at 13 bits, tag from the slot's own block
            blk = fetch_addr[15:3] + 13'(i);
            exp_valid = m_valid[blk[4:0]] && (m_tag[blk[4:0]] == blk[12:5]);
            compare(window_valid[i], exp_valid, $sformatf("window_valid[%0d]", i));
            compare(window_alloc[i], m_alloc[blk[4:0]], $sformatf("window_alloc[%0d]", i));
            if (exp_valid) begin
                compare(window_data[i], block_pattern(blk), $sformatf("window_data[%0d]", i));
            end
        end
        compare(wb_cyc, m_state == icache_pkg::FILL_REQ, "wb_cyc");
        compare(wb_stb, m_state == icache_pkg::FILL_REQ, "wb_stb");
        // read only master, whole block selected
        compare(wb_we, 1'b0, "wb_we");
        compare(wb_sel, {`ICACHE_BLOCK_BYTES{1'b1}}, "wb_sel");
        if (m_state == icache_pkg::FILL_REQ) begin
            compare(wb_adr, {m_fill, 3'b000}, "wb_adr");
        end
    endtask

    // one clock: model at the edge, inputs just after, checks at the falling edge
    task automatic run_cycle(input icache_pkg::addr_t addr, input logic sq, input logic rst);
        @(posedge clock);
        update_model();
        #1;
        reset = rst;
        fetch_addr = addr;
        squash = sq;
        respond_memory();
        @(negedge clock);
        check_outputs();
    endtask

    // hold an address until slot 0 turns valid
    task automatic wait_fill(input icache_pkg::addr_t addr);
        int n;
        n = 0;
        do begin
            run_cycle(addr, 1'b0, 1'b0);
            n++;
        end while (!window_valid[0] && n < FILL_LIMIT);
        assert (window_valid[0]) else begin
            $display("fill of address %h did not finish within %0d cycles", addr, FILL_LIMIT);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        tests_done++;
        $display("test %0d %s: %0d errors", tests_done, name, error_count - test_base);
        test_base = error_count;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        fetch_addr = '0;
        squash = 1'b0;
        wb_ack = 1'b0;
        wb_dat_i = '0;

        // random addresses during reset, nothing valid or allocated
        for (int c = 0; c < 10; c++) begin
            run_cycle(random_addr(), 1'b0, c < 9);
        end
        end_test("reset state");

        // directed tests use tags above the random range
        wait_fill(fetch_addr);
        a = 16'h2000 | (random_addr() & 16'h00ff);
        start_acks = ack_count;
        wait_fill(a);
        compare(ack_count - start_acks, 1, "reads per miss");
        compare(window_data[0], block_pattern(a[15:3]), "filled block");
        end_test("single miss fill");

        // index 31, slot 1 wraps to index 0 with the next tag
        a = {8'd40, 5'd31, 3'd0};
        wait_fill(a + 16'd8);
        wait_fill(a);
        compare(window_valid[1], 1'b1, "slot 1 valid at wrap");
        compare(window_data[1], block_pattern(a[15:3] + 13'd1), "slot 1 data at wrap");
        end_test("slot 1 and window wrap");

        // squash lands at the edge after the alloc edge, before any write can
        b = 16'h3000 | (random_addr() & 16'h00ff);
        run_cycle(b, 1'b0, 1'b0);
        run_cycle(b, 1'b1, 1'b0);
        compare(window_alloc[0], 1'b1, "alloc before squash");
        run_cycle(b, 1'b0, 1'b0);
        compare(window_alloc[0], 1'b0, "alloc after squash");
        wait_fill(b);
        end_test("squash during fill");

        // same index, other tag
        a = 16'h4000 | (random_addr() & 16'h00ff);
        b = a ^ 16'h0100;
        wait_fill(a);
        wait_fill(b);
        run_cycle(a, 1'b0, 1'b0);
        compare(window_valid[0], 1'b0, "evicted line");
        wait_fill(a);
        end_test("conflict eviction");

        // about one squash in eight cycles
        for (int c = 0; c < 300; c++) begin
            run_cycle(random_addr(), rand_bits(3) == 0, 1'b0);
        end
        end_test("random stream");

        violations = u_dut.u_fill.u_checker.violations;
        $display("tests %0d, checks %0d, errors %0d, protocol violations %0d",
                 tests_done, check_count, error_count, violations);
        if (error_count == 0 && violations == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // bound from the cycle budget of all tests
    initial begin
        #(TEST_CYCLES * 20 * 10);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
hdl/icache_pkg.sv
hdl/icache_data_array.sv
hdl/icache_tag_store.sv
hdl/icache_fill.sv
hdl/icache_top.sv
testbench/icache_checker.sv
testbench/icache_tb.sv
